// ==== l2_cfg_pkg.sv ====
package l2_cfg_pkg;

    // Cache geometry
    localparam int L2_SETS        = 16;
    localparam int L2_SET_BITS    = 4;
    localparam int L2_WAYS        = 4;
    localparam int L2_WAY_BITS    = 2;
    localparam int OFFSET_BITS    = 4;                            // Byte offset in a line
    localparam int ADDR_BITS      = 16;
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;      // 12
    localparam int L2_TAG_BITS    = LINE_ADDR_BITS - L2_SET_BITS; // 8

    typedef logic [L2_SET_BITS-1:0]    l2_set_t;
    typedef logic [L2_WAY_BITS-1:0]    l2_way_t;
    typedef logic [L2_TAG_BITS-1:0]    l2_tag_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [OFFSET_BITS-1:0]    offset_t;

    typedef struct packed {
        l2_tag_t tag;
        l2_set_t set;
        offset_t offset;
    } addr_fields_t;

    typedef struct packed {
        line_addr_t line_addr;
        offset_t    offset;
    } addr_line_t;

    // Same address word, cache index view or line view
    typedef union packed {
        addr_fields_t f;
        addr_line_t   l;
    } addr_u;

endpackage

// ==== l2_coh_pkg.sv ====
package l2_coh_pkg;

    // Stable MESI-style line states
    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        SHARED    = 2'b01,
        EXCLUSIVE = 2'b10,
        MODIFIED  = 2'b11
    } state_t;

    // Requests from the CPU side
    typedef enum logic [1:0] {
        READ        = 2'b00,
        READ_ATOMIC = 2'b01,
        WRITE       = 2'b10
    } cpu_msg_t;

    // Coherence requests to the next level
    typedef enum logic [1:0] {
        REQ_S = 2'b00,
        REQ_E = 2'b01,
        REQ_M = 2'b10
    } coh_msg_t;

endpackage

// ==== l2_array_if.sv ====
`timescale 1ns/100ps

interface l2_array_if import l2_cfg_pkg::*; ();

    l2_set_t    set;
    logic       wr_en;
    l2_way_t    wr_way;       // Also addresses the way tag read
    logic [1:0] wr_state;
    l2_tag_t    wr_tag;
    l2_tag_t    lookup_tag;

    logic       hit;
    l2_way_t    hit_way;
    logic [1:0] hit_state;
    logic       empty_found;
    l2_way_t    empty_way;
    l2_tag_t    way_tag;      // Tag held at set / wr_way

    modport ctrl (
        output set, wr_en, wr_way, wr_state, wr_tag, lookup_tag,
        input  hit, hit_way, hit_state, empty_found, empty_way, way_tag
    );

    modport store (
        input  set, wr_en, wr_way, wr_state, wr_tag, lookup_tag,
        output hit, hit_way, hit_state, empty_found, empty_way, way_tag
    );

endinterface

// ==== l2_tag_store.sv ====
`timescale 1ns/100ps

module l2_tag_store
    import l2_cfg_pkg::*;
    import l2_coh_pkg::*;
(
    input logic       clk,
    input logic       rst,
    l2_array_if.store arr_o
);

    state_t  states [L2_SETS][L2_WAYS];
    l2_tag_t tags   [L2_SETS][L2_WAYS];

    // ======================================================================
    // Write port
    // ======================================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < L2_SETS; s++) begin
                for (int w = 0; w < L2_WAYS; w++) begin
                    states[s][w] <= INVALID;
                end
            end
        end else if (arr_o.wr_en) begin
            if (arr_o.wr_state == INVALID) begin
                for (int w = 0; w < L2_WAYS; w++) begin
                    states[arr_o.set][w] <= INVALID; // Sweep clears whole set
                end
            end else begin
                states[arr_o.set][arr_o.wr_way] <= state_t'(arr_o.wr_state);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr_o.wr_en) begin
            tags[arr_o.set][arr_o.wr_way] <= arr_o.wr_tag;
        end
    end

    // ======================================================================
    // Lookup
    // ======================================================================
    always_comb begin
        arr_o.hit         = 1'b0;
        arr_o.hit_way     = '0;
        arr_o.hit_state   = INVALID;
        arr_o.empty_found = 1'b0;
        arr_o.empty_way   = '0;
        for (int w = 0; w < L2_WAYS; w++) begin
            if (states[arr_o.set][w] != INVALID && tags[arr_o.set][w] == arr_o.lookup_tag) begin
                arr_o.hit       = 1'b1;
                arr_o.hit_way   = L2_WAY_BITS'(w);
                arr_o.hit_state = states[arr_o.set][w];
            end
        end
        for (int w = L2_WAYS - 1; w >= 0; w--) begin
            if (states[arr_o.set][w] == INVALID) begin
                arr_o.empty_found = 1'b1;
                arr_o.empty_way   = L2_WAY_BITS'(w); // Lowest one wins
            end
        end
    end

    assign arr_o.way_tag = tags[arr_o.set][arr_o.wr_way];

endmodule

// ==== l2_sweep_counter.sv ====
`timescale 1ns/100ps

module l2_sweep_counter
    import l2_cfg_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    sweep_en_i,
    input  logic    victim_adv_i,
    output l2_set_t sweep_set_o,
    output logic    sweep_last_o,
    output l2_way_t victim_way_o
);

    l2_set_t sweep_set;
    l2_way_t victim_way;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweep_set <= '0;
        end else if (sweep_en_i) begin
            sweep_set <= sweep_set + 1'b1;
        end
    end

    // Global round-robin victim
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            victim_way <= '0;
        end else if (victim_adv_i) begin
            if (victim_way == L2_WAY_BITS'(L2_WAYS - 1)) begin
                victim_way <= '0;
            end else begin
                victim_way <= victim_way + 1'b1;
            end
        end
    end

    assign sweep_set_o  = sweep_set;
    assign sweep_last_o = (sweep_set == L2_SET_BITS'(L2_SETS - 1));
    assign victim_way_o = victim_way;

endmodule

// ==== l2_ctrl_fsm.sv ====
`timescale 1ns/100ps

module l2_ctrl_fsm
    import l2_cfg_pkg::*;
    import l2_coh_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    l2_array_if.ctrl   arr_i,
    input  l2_set_t    sweep_set_i,
    input  logic       sweep_last_i,
    input  l2_way_t    victim_way_i,
    output logic       sweep_en_o,
    output logic       victim_adv_o,
    input  logic       cpu_req_valid_i,
    input  cpu_msg_t   cpu_req_msg_i,
    input  addr_u      cpu_req_addr_i,
    output logic       cpu_req_ready_o,
    input  logic       rd_rsp_ready_i,
    output logic       rd_rsp_valid_o,
    output line_addr_t rd_rsp_addr_o,
    input  logic       req_out_ready_i,
    output logic       req_out_valid_o,
    output coh_msg_t   req_out_msg_o,
    output line_addr_t req_out_addr_o,
    input  logic       inval_ready_i,
    output logic       inval_valid_o,
    output line_addr_t inval_addr_o
);

    typedef enum logic [3:0] {
        RESET, DECODE, TAG_LOOKUP, READ_EM, READ_HIT,
        UPGRADE_S, WRITE_EM, EMPTY_WAY, EVICT
    } fsm_state_t;

    fsm_state_t state, next_state;
    cpu_msg_t   req_msg_q;
    addr_u      req_addr_q;
    l2_way_t    way_q;
    l2_tag_t    victim_tag_q;
    logic [1:0] ready_bits;     // [0] inval done, [1] req_out done
    state_t     hit_st;
    logic       hit_em;
    logic       evict_done;
    logic       action_done;
    state_t     fill_state;
    coh_msg_t   fill_msg;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid_i && cpu_req_ready_o) begin
            req_msg_q  <= cpu_req_msg_i;
            req_addr_q <= cpu_req_addr_i;
        end
        if (state == TAG_LOOKUP) begin
            if (arr_i.hit) begin
                way_q <= arr_i.hit_way;
            end else if (arr_i.empty_found) begin
                way_q <= arr_i.empty_way;
            end else begin
                way_q <= victim_way_i;
            end
            victim_tag_q <= arr_i.way_tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ready_bits <= '0;
        end else if (state == DECODE) begin
            ready_bits <= '0;
        end else if (state == EVICT) begin
            if (inval_valid_o && inval_ready_i) begin
                ready_bits[0] <= 1'b1;
            end
            if (req_out_valid_o && req_out_ready_i) begin
                ready_bits[1] <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Classification and sequencing
    // ======================================================================
    assign hit_st     = state_t'(arr_i.hit_state);
    assign hit_em     = (hit_st == EXCLUSIVE) || (hit_st == MODIFIED);
    assign evict_done = (ready_bits[0] || inval_ready_i) && (ready_bits[1] || req_out_ready_i);

    always_comb begin
        case (req_msg_q)
            READ_ATOMIC: begin
                fill_state = EXCLUSIVE;
                fill_msg   = REQ_E;
            end
            WRITE: begin
                fill_state = MODIFIED;
                fill_msg   = REQ_M;
            end
            default: begin
                fill_state = SHARED;
                fill_msg   = REQ_S;
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                if (sweep_last_i) begin
                    next_state = DECODE;
                end
            end
            DECODE: begin
                if (cpu_req_valid_i) begin
                    next_state = TAG_LOOKUP;
                end
            end
            TAG_LOOKUP: begin
                if (arr_i.hit) begin
                    if (req_msg_q == READ) begin
                        next_state = READ_HIT;
                    end else if (hit_em) begin
                        next_state = (req_msg_q == READ_ATOMIC) ? READ_EM : WRITE_EM;
                    end else begin
                        next_state = UPGRADE_S;
                    end
                end else if (arr_i.empty_found) begin
                    next_state = EMPTY_WAY;
                end else begin
                    next_state = EVICT;
                end
            end
            READ_HIT, READ_EM: begin
                if (rd_rsp_ready_i) begin
                    next_state = DECODE;
                end
            end
            UPGRADE_S, EMPTY_WAY: begin
                if (req_out_ready_i) begin
                    next_state = DECODE;
                end
            end
            WRITE_EM: begin
                next_state = DECODE;
            end
            EVICT: begin
                if (evict_done) begin
                    next_state = DECODE;
                end
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // Array written as the action completes
    assign action_done = (state == READ_EM && rd_rsp_ready_i)
                      || (state == UPGRADE_S && req_out_ready_i)
                      || (state == WRITE_EM)
                      || (state == EMPTY_WAY && req_out_ready_i)
                      || (state == EVICT && evict_done);

    // ======================================================================
    // Array and port drive
    // ======================================================================
    assign arr_i.set        = (state == RESET) ? sweep_set_i : req_addr_q.f.set;
    assign arr_i.lookup_tag = req_addr_q.f.tag;
    assign arr_i.wr_tag     = req_addr_q.f.tag;
    assign arr_i.wr_way     = (state == TAG_LOOKUP) ? victim_way_i : way_q;
    assign arr_i.wr_en      = (state == RESET) || action_done;

    always_comb begin
        if (state == RESET) begin
            arr_i.wr_state = INVALID;
        end else if (state == EMPTY_WAY || state == EVICT) begin
            arr_i.wr_state = fill_state;
        end else begin
            arr_i.wr_state = MODIFIED; // Hit upgrades end in M
        end
    end

    assign sweep_en_o      = (state == RESET);
    assign victim_adv_o    = (state == EVICT) && evict_done;
    assign cpu_req_ready_o = (state == DECODE);

    assign rd_rsp_valid_o  = (state == READ_HIT) || (state == READ_EM);
    assign req_out_valid_o = (state == UPGRADE_S) || (state == EMPTY_WAY)
                          || (state == EVICT && !ready_bits[1]);
    assign inval_valid_o   = (state == EVICT) && !ready_bits[0];

    assign rd_rsp_addr_o  = req_addr_q.l.line_addr;
    assign req_out_addr_o = req_addr_q.l.line_addr;
    assign req_out_msg_o  = (state == UPGRADE_S) ? REQ_M : fill_msg;
    assign inval_addr_o   = {victim_tag_q, req_addr_q.f.set};

endmodule

// ==== l2_ctrl_top.sv ====
`timescale 1ns/100ps

module l2_ctrl_top
    import l2_cfg_pkg::*;
    import l2_coh_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_req_valid_i,
    input  cpu_msg_t   cpu_req_msg_i,
    input  addr_u      cpu_req_addr_i,
    output logic       cpu_req_ready_o,
    output logic       rd_rsp_valid_o,
    output line_addr_t rd_rsp_addr_o,
    input  logic       rd_rsp_ready_i,
    output logic       req_out_valid_o,
    output coh_msg_t   req_out_msg_o,
    output line_addr_t req_out_addr_o,
    input  logic       req_out_ready_i,
    output logic       inval_valid_o,
    output line_addr_t inval_addr_o,
    input  logic       inval_ready_i
);

    logic    sweep_en;
    logic    victim_adv;
    l2_set_t sweep_set;
    logic    sweep_last;
    l2_way_t victim_way;

    l2_array_if arr_if_i ();

    l2_tag_store store_i (
        .clk   (clk),
        .rst   (rst),
        .arr_o (arr_if_i.store)
    );

    l2_sweep_counter counter_i (
        .clk          (clk),
        .rst          (rst),
        .sweep_en_i   (sweep_en),
        .victim_adv_i (victim_adv),
        .sweep_set_o  (sweep_set),
        .sweep_last_o (sweep_last),
        .victim_way_o (victim_way)
    );

    l2_ctrl_fsm fsm_i (
        .clk             (clk),
        .rst             (rst),
        .arr_i           (arr_if_i.ctrl),
        .sweep_set_i     (sweep_set),
        .sweep_last_i    (sweep_last),
        .victim_way_i    (victim_way),
        .sweep_en_o      (sweep_en),
        .victim_adv_o    (victim_adv),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_msg_i   (cpu_req_msg_i),
        .cpu_req_addr_i  (cpu_req_addr_i),
        .cpu_req_ready_o (cpu_req_ready_o),
        .rd_rsp_ready_i  (rd_rsp_ready_i),
        .rd_rsp_valid_o  (rd_rsp_valid_o),
        .rd_rsp_addr_o   (rd_rsp_addr_o),
        .req_out_ready_i (req_out_ready_i),
        .req_out_valid_o (req_out_valid_o),
        .req_out_msg_o   (req_out_msg_o),
        .req_out_addr_o  (req_out_addr_o),
        .inval_ready_i   (inval_ready_i),
        .inval_valid_o   (inval_valid_o),
        .inval_addr_o    (inval_addr_o)
    );

endmodule

// ==== l2_ctrl_assertions.sv ====
`timescale 1ns/100ps

module l2_ctrl_assertions
    import l2_cfg_pkg::*;
    import l2_coh_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       cpu_ready_i,
    input logic       rd_valid_i,
    input logic       rd_ready_i,
    input line_addr_t rd_addr_i,
    input logic       req_valid_i,
    input logic       req_ready_i,
    input coh_msg_t   req_msg_i,
    input line_addr_t req_addr_i,
    input logic       inv_valid_i,
    input logic       inv_ready_i,
    input line_addr_t inv_addr_i
);

    int fail_count = 0;     // Failures seen so far

    // ======================================================================
    // Handshake hold rules
    // ======================================================================
    rd_held: assert property (@(posedge clk) disable iff (!rst)
        rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_addr_i))
    else begin
        $error("read response dropped or changed before its transfer");
        fail_count++;
    end

    req_held: assert property (@(posedge clk) disable iff (!rst)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_msg_i) && $stable(req_addr_i))
    else begin
        $error("outgoing request dropped or changed before its transfer");
        fail_count++;
    end

    inv_held: assert property (@(posedge clk) disable iff (!rst)
        inv_valid_i && !inv_ready_i |=> inv_valid_i && $stable(inv_addr_i))
    else begin
        $error("invalidate dropped or changed before its transfer");
        fail_count++;
    end

    // ======================================================================
    // Exclusivity
    // ======================================================================
    idle_quiet: assert property (@(posedge clk) disable iff (!rst)
        cpu_ready_i |-> !(rd_valid_i || req_valid_i || inv_valid_i))
    else begin
        $error("output valid while a new CPU request can be accepted");
        fail_count++;
    end

    rd_inv_apart: assert property (@(posedge clk) disable iff (!rst)
        !(rd_valid_i && inv_valid_i))
    else begin
        $error("read response and invalidate valid in the same cycle");
        fail_count++;
    end

endmodule

// ==== tb_l2_ctrl.sv ====
`timescale 1ns/100ps

module tb_l2_ctrl
    import l2_cfg_pkg::*;
    import l2_coh_pkg::*;
();

    localparam int KIND_RD     = 0;
    localparam int KIND_REQ    = 1;
    localparam int KIND_EVICT  = 2;
    localparam int KIND_SILENT = 3;
    localparam int REQ_COUNT   = 2 + 4 + 7 + 300;
    localparam int MAX_CYCLES  = REQ_COUNT * 40 + 8 + L2_SETS;

    logic       clk;
    logic       rst;
    logic       cpu_req_valid_i;
    cpu_msg_t   cpu_req_msg_i;
    addr_u      cpu_req_addr_i;
    logic       cpu_req_ready_o;
    logic       rd_rsp_valid_o;
    line_addr_t rd_rsp_addr_o;
    logic       rd_rsp_ready_i;
    logic       req_out_valid_o;
    coh_msg_t   req_out_msg_o;
    line_addr_t req_out_addr_o;
    logic       req_out_ready_i;
    logic       inval_valid_o;
    line_addr_t inval_addr_o;
    logic       inval_ready_i;

    state_t     model_state [L2_SETS][L2_WAYS];
    l2_tag_t    model_tag   [L2_SETS][L2_WAYS];
    l2_way_t    model_victim;
    line_addr_t exp_rd_q [$];
    coh_msg_t   exp_req_msg_q [$];
    line_addr_t exp_req_addr_q [$];
    line_addr_t exp_inval_q [$];
    string      test_name;
    int         test_errors;
    int         error_total;
    int         tests_run;
    int         tests_bad;
    int         split_evicts;
    int         cycle_count;
    logic       backpressure;

    l2_ctrl_top dut_i (.*);

    bind l2_ctrl_top l2_ctrl_assertions chk_i (
        .clk         (clk),
        .rst         (rst),
        .cpu_ready_i (cpu_req_ready_o),
        .rd_valid_i  (rd_rsp_valid_o),
        .rd_ready_i  (rd_rsp_ready_i),
        .rd_addr_i   (rd_rsp_addr_o),
        .req_valid_i (req_out_valid_o),
        .req_ready_i (req_out_ready_i),
        .req_msg_i   (req_out_msg_o),
        .req_addr_i  (req_out_addr_o),
        .inv_valid_i (inval_valid_o),
        .inv_ready_i (inval_ready_i),
        .inv_addr_i  (inval_addr_o)
    );

    always #5 clk = ~clk;

    task automatic value_error(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic plain_error(input string text);
        $display("%s: %s", test_name, text);
        test_errors++;
    endtask

    task automatic finish_test();
        $display("[DONE] %s, %0d errors", test_name, test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_bad++;
        end
        error_total += test_errors;
        test_errors = 0;
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic void predict(input cpu_msg_t msg, input addr_u addr, output int kind,
                                    output coh_msg_t emsg, output line_addr_t inv_addr);
        l2_set_t s;
        l2_way_t way;
        logic    hit;
        logic    empty;
        state_t  fill;
        s        = addr.f.set;
        hit      = 1'b0;
        empty    = 1'b0;
        way      = '0;
        kind     = KIND_REQ;
        emsg     = REQ_M;
        inv_addr = '0;
        for (int w = 0; w < L2_WAYS; w++) begin
            if (model_state[s][w] != INVALID && model_tag[s][w] == addr.f.tag) begin
                hit = 1'b1;
                way = L2_WAY_BITS'(w);
            end
        end
        if (hit) begin
            if (msg == READ) begin
                kind = KIND_RD;
            end else begin
                if (model_state[s][way] == SHARED) begin
                    kind = KIND_REQ;                 // Upgrade needs M permission
                end else begin
                    kind = (msg == READ_ATOMIC) ? KIND_RD : KIND_SILENT;
                end
                model_state[s][way] = MODIFIED;
            end
        end else begin
            emsg = (msg == READ) ? REQ_S : (msg == READ_ATOMIC) ? REQ_E : REQ_M;
            fill = (msg == READ) ? SHARED : (msg == READ_ATOMIC) ? EXCLUSIVE : MODIFIED;
            for (int w = 0; w < L2_WAYS; w++) begin
                if (!empty && model_state[s][w] == INVALID) begin
                    empty = 1'b1;
                    way   = L2_WAY_BITS'(w);
                end
            end
            if (!empty) begin
                way          = model_victim;
                kind         = KIND_EVICT;
                inv_addr     = {model_tag[s][way], s};
                model_victim = (model_victim == L2_WAY_BITS'(L2_WAYS - 1)) ? '0 : model_victim + 1'b1;
            end
            model_state[s][way] = fill;
            model_tag[s][way]   = addr.f.tag;
        end
    endfunction

    task automatic issue_request(input cpu_msg_t msg, input l2_tag_t tag, input l2_set_t set);
        addr_u      addr;
        int         kind;
        coh_msg_t   emsg;
        line_addr_t inv_addr;
        addr.f.tag    = tag;
        addr.f.set    = set;
        addr.f.offset = OFFSET_BITS'($urandom_range(15, 0));
        predict(msg, addr, kind, emsg, inv_addr);
        if (kind == KIND_RD) begin
            exp_rd_q.push_back(addr.l.line_addr);
        end else if (kind != KIND_SILENT) begin
            exp_req_msg_q.push_back(emsg);
            exp_req_addr_q.push_back(addr.l.line_addr);
        end
        if (kind == KIND_EVICT) begin
            exp_inval_q.push_back(inv_addr);
        end
        cpu_req_valid_i = 1'b1;
        cpu_req_msg_i   = msg;
        cpu_req_addr_i  = addr;
        do begin
            @(posedge clk);
        end while (!cpu_req_ready_o);
        @(negedge clk);
        cpu_req_valid_i = 1'b0;
        while (!cpu_req_ready_o) begin
            @(negedge clk);
        end
        if (exp_rd_q.size() != 0 || exp_req_msg_q.size() != 0 || exp_inval_q.size() != 0) begin
            plain_error("an expected transfer did not happen before the request ended");
            exp_rd_q.delete();
            exp_req_msg_q.delete();
            exp_req_addr_q.delete();
            exp_inval_q.delete();
        end
    endtask

    // ======================================================================
    // Transfer comparison, back-pressure and watchdog
    // ======================================================================
    always @(posedge clk) begin : compare_transfers
        line_addr_t exp_addr;
        coh_msg_t   exp_msg;
        logic       req_xfer;
        logic       inv_xfer;
        req_xfer = req_out_valid_o && req_out_ready_i;
        inv_xfer = inval_valid_o && inval_ready_i;
        if (req_out_valid_o && inval_valid_o && (req_xfer != inv_xfer)) begin
            split_evicts++;
        end
        if (rd_rsp_valid_o && rd_rsp_ready_i) begin
            if (exp_rd_q.size() == 0) begin
                plain_error("a read response arrived with none expected");
            end else begin
                exp_addr = exp_rd_q.pop_front();
                if (rd_rsp_addr_o !== exp_addr) begin
                    value_error("rd_rsp addr", 16'(exp_addr), 16'(rd_rsp_addr_o));
                end
            end
        end
        if (req_xfer) begin
            if (exp_req_msg_q.size() == 0) begin
                plain_error("an outgoing request arrived with none expected");
            end else begin
                exp_msg  = exp_req_msg_q.pop_front();
                exp_addr = exp_req_addr_q.pop_front();
                if (req_out_msg_o !== exp_msg) begin
                    value_error("req_out msg", 16'(exp_msg), 16'(req_out_msg_o));
                end
                if (req_out_addr_o !== exp_addr) begin
                    value_error("req_out addr", 16'(exp_addr), 16'(req_out_addr_o));
                end
            end
        end
        if (inv_xfer) begin
            if (exp_inval_q.size() == 0) begin
                plain_error("an invalidate arrived with none expected");
            end else begin
                exp_addr = exp_inval_q.pop_front();
                if (inval_addr_o !== exp_addr) begin
                    value_error("inval addr", 16'(exp_addr), 16'(inval_addr_o));
                end
            end
        end
    end

    always @(negedge clk) begin
        if (backpressure) begin
            rd_rsp_ready_i  = ($urandom % 4) != 0;
            req_out_ready_i = ($urandom % 4) != 0;
            inval_ready_i   = ($urandom % 4) != 0;
        end else begin
            rd_rsp_ready_i  = 1'b1;
            req_out_ready_i = 1'b1;
            inval_ready_i   = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped completing requests", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin : run_tests
        int cycles;
        void'($urandom(75599));
        clk             = 1'b0;
        rst             = 1'b0;
        cpu_req_valid_i = 1'b0;
        cpu_req_msg_i   = READ;
        cpu_req_addr_i  = '0;
        rd_rsp_ready_i  = 1'b1;
        req_out_ready_i = 1'b1;
        inval_ready_i   = 1'b1;
        backpressure    = 1'b0;
        test_errors     = 0;
        error_total     = 0;
        tests_run       = 0;
        tests_bad       = 0;
        split_evicts    = 0;
        cycle_count     = 0;
        model_victim    = '0;
        for (int s = 0; s < L2_SETS; s++) begin
            for (int w = 0; w < L2_WAYS; w++) begin
                model_state[s][w] = INVALID;
                model_tag[s][w]   = '0;
            end
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_name = "reset";
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (rd_rsp_valid_o || req_out_valid_o || inval_valid_o) begin
                plain_error("a valid output rose during the reset sweep");
            end
        end while (!cpu_req_ready_o && cycles < 4 * L2_SETS);
        if (cycles != L2_SETS) begin
            value_error("ready delay", 16'(L2_SETS), 16'(cycles));
        end
        repeat (3) begin
            @(negedge clk);
            if (!cpu_req_ready_o) begin
                plain_error("cpu_req_ready_o fell with no request accepted");
            end
        end
        finish_test();

        test_name = "read_hit";
        issue_request(READ, 8'h21, 4'h3);
        issue_request(READ, 8'h21, 4'h3);
        finish_test();

        test_name = "upgrade";
        issue_request(WRITE, 8'h21, 4'h3);          // S to M
        issue_request(WRITE, 8'h21, 4'h3);
        issue_request(READ_ATOMIC, 8'h44, 4'h3);
        issue_request(READ_ATOMIC, 8'h44, 4'h3);
        finish_test();

        test_name = "evict";
        for (int i = 0; i < 7; i++) begin
            issue_request(READ, L2_TAG_BITS'(8'h50 + i), 4'h5);
        end
        finish_test();

        test_name    = "random";
        backpressure = 1'b1;
        repeat (300) begin
            issue_request(cpu_msg_t'($urandom_range(2, 0)), L2_TAG_BITS'($urandom_range(7, 0)),
                          L2_SET_BITS'($urandom_range(2, 0)));
        end
        if (split_evicts == 0) begin
            plain_error("no eviction had its two handshakes in separate cycles");
        end
        finish_test();
        backpressure = 1'b0;

        if (dut_i.chk_i.fail_count != 0) begin
            $display("%0d assertion failures", dut_i.chk_i.fail_count);
            error_total += dut_i.chk_i.fail_count;
        end
        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, error_total);
        if (error_total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== l2_ctrl_top.f ====
l2_cfg_pkg.sv
l2_coh_pkg.sv
l2_array_if.sv
l2_tag_store.sv
l2_sweep_counter.sv
l2_ctrl_fsm.sv
l2_ctrl_top.sv
l2_ctrl_assertions.sv
tb_l2_ctrl.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = tb_l2_ctrl
FILELIST = l2_ctrl_top.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
SIM_ARGS = +verilator+error+limit+100
LOG      = sim.log
FAIL_MSG = tests failed
PASS_MSG = all tests passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
